// File: common/ppu_params.svh
`ifndef PPU_PARAMS_SVH
`define PPU_PARAMS_SVH

// cpu data bus and memory data
`define PPU_DATA_W 8

// temporary and current video address
`define PPU_VADDR_W 15

// pattern memory, 8 KiB
`define PPU_CHR_AW 13

// nametable memory, two 1 KiB pages
`define PPU_NT_AW 11

// palette memory, 32 entries
`define PPU_PAL_AW 5

`endif

// File: common/ppu_pkg.sv
package ppu_pkg;

`include "ppu_params.svh"

    // cpu register selects, OAMDMA keeps its slot but does nothing here
    typedef enum logic [3:0] {
        PPUCTRL   = 4'd0,
        PPUMASK   = 4'd1,
        PPUSTATUS = 4'd2,
        OAMADDR   = 4'd3,
        OAMDATA   = 4'd4,
        PPUSCROLL = 4'd5,
        PPUADDR   = 4'd6,
        PPUDATA   = 4'd7,
        OAMDMA    = 4'd8
    } reg_sel_t;

    typedef enum logic {
        MIRROR_HORZ = 1'b0,
        MIRROR_VERT = 1'b1
    } mirror_t;

    // one cpu bus cycle, wr = 1 for a write
    typedef struct packed {
        reg_sel_t                sel;
        logic                    en;
        logic                    wr;
        logic [`PPU_DATA_W-1:0]  wdata;
    } cpu_req_t;

    typedef struct packed {
        logic [`PPU_CHR_AW-1:0]  addr;
        logic                    re;
        logic                    we;
        logic [`PPU_DATA_W-1:0]  wdata;
    } chr_port_t;

    typedef struct packed {
        logic [`PPU_NT_AW-1:0]   addr;
        logic                    re;
        logic                    we;
        logic [`PPU_DATA_W-1:0]  wdata;
    } nt_port_t;

    typedef struct packed {
        logic [`PPU_PAL_AW-1:0]  addr;
        logic                    re;
        logic                    we;
        logic [`PPU_DATA_W-1:0]  wdata;
    } pal_port_t;

    typedef struct packed {
        logic [7:0]              addr;
        logic                    re;
        logic                    we;
        logic [`PPU_DATA_W-1:0]  wdata;
    } oam_port_t;

    // event strobes from the render side
    typedef struct packed {
        logic ovr_set;
        logic ovr_clr;
        logic zero_set;
        logic zero_clr;
        logic vbl_set;
        logic vbl_clr;
    } status_evt_t;

    // bypass marks palette data, which skips the read buffer
    typedef struct packed {
        logic [`PPU_DATA_W-1:0]  data;
        logic                    bypass;
    } vdata_rd_t;

endpackage

// File: hw/ppu_regs.sv
`timescale 1ns/1ps
`include "ppu_params.svh"

module ppu_regs (
    input  logic                    clk,
    input  logic                    rst_n,
    input  ppu_pkg::cpu_req_t       cpu_req,
    input  logic [`PPU_DATA_W-1:0]  status_byte,
    input  ppu_pkg::vdata_rd_t      vdata_rd,
    input  logic [`PPU_DATA_W-1:0]  oam_rd_data,
    output ppu_pkg::oam_port_t      oam,
    output logic                    vram_inc_32,
    output logic [`PPU_DATA_W-1:0]  ctrl,
    output logic [`PPU_DATA_W-1:0]  mask,
    output logic [`PPU_DATA_W-1:0]  read_data
);
    import ppu_pkg::*;

    logic [7:0]             oam_addr_q;
    logic [`PPU_DATA_W-1:0] rd_buf;
    logic                   wr_acc;
    logic                   rd_acc;

    assign wr_acc = cpu_req.en && cpu_req.wr;
    assign rd_acc = cpu_req.en && !cpu_req.wr;

    // step size for the video address, 32 walks down a nametable column
    assign vram_inc_32 = ctrl[2];

    // OAM is accessed at OAMADDR in the cycle of the OAMDATA access
    always_comb begin
        oam.addr  = oam_addr_q;
        oam.re    = rd_acc && (cpu_req.sel == OAMDATA);
        oam.we    = wr_acc && (cpu_req.sel == OAMDATA);
        oam.wdata = cpu_req.wdata;
    end

    // write-side registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl       <= '0;
            mask       <= '0;
            oam_addr_q <= '0;
        end else if (wr_acc) begin
            case (cpu_req.sel)
                PPUCTRL: begin
                    ctrl <= cpu_req.wdata;
                end
                PPUMASK: begin
                    mask <= cpu_req.wdata;
                end
                OAMADDR: begin
                    oam_addr_q <= cpu_req.wdata;
                end
                OAMDATA: begin
                    // auto increment after each data write
                    oam_addr_q <= oam_addr_q + 8'd1;
                end
                default: begin
                end
            endcase
        end
    end

    // read data holds until the next read of a readable register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            read_data <= '0;
            rd_buf    <= '0;
        end else if (rd_acc) begin
            case (cpu_req.sel)
                PPUSTATUS: begin
                    read_data <= status_byte;
                end
                OAMDATA: begin
                    read_data <= oam_rd_data;
                end
                PPUDATA: begin
                    if (vdata_rd.bypass) begin
                        // palette comes straight through, buffer untouched
                        read_data <= vdata_rd.data;
                    end else begin
                        // one read late: return old buffer, refill it
                        read_data <= rd_buf;
                        rd_buf    <= vdata_rd.data;
                    end
                end
                default: begin
                end
            endcase
        end
    end

endmodule

// File: hw/ppu_status.sv
`timescale 1ns/1ps
`include "ppu_params.svh"

module ppu_status (
    input  logic                    clk,
    input  logic                    rst_n,
    input  ppu_pkg::cpu_req_t       cpu_req,
    input  ppu_pkg::status_evt_t    status_evt,
    output logic [`PPU_DATA_W-1:0]  status_byte
);
    import ppu_pkg::*;

    logic       ovr_flag;
    logic       zero_flag;
    logic       vbl_flag;
    logic [4:0] last_wr;
    logic       status_rd;

    assign status_rd = cpu_req.en && !cpu_req.wr && (cpu_req.sel == PPUSTATUS);

    // bit 7 vblank, 6 sprite zero, 5 overflow, rest is bus residue
    assign status_byte = {vbl_flag, zero_flag, ovr_flag, last_wr};

    // clear is checked last so it wins over a set
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ovr_flag  <= 1'b0;
            zero_flag <= 1'b0;
            vbl_flag  <= 1'b0;
            last_wr   <= '0;
        end else begin
            if (status_evt.ovr_set) ovr_flag <= 1'b1;
            if (status_evt.ovr_clr) ovr_flag <= 1'b0;

            if (status_evt.zero_set) zero_flag <= 1'b1;
            if (status_evt.zero_clr) zero_flag <= 1'b0;

            if (status_evt.vbl_set) vbl_flag <= 1'b1;
            if (status_evt.vbl_clr || status_rd) vbl_flag <= 1'b0;

            // any register write leaves its low bits behind
            if (cpu_req.en && cpu_req.wr) begin
                last_wr <= cpu_req.wdata[4:0];
            end
        end
    end

endmodule

// File: vram_addr/loopy_addr.sv
`timescale 1ns/1ps
`include "ppu_params.svh"

module loopy_addr (
    input  logic                     clk,
    input  logic                     rst_n,
    input  ppu_pkg::cpu_req_t        cpu_req,
    input  logic                     vram_inc_32,
    output logic [`PPU_VADDR_W-1:0]  video_addr,
    output logic [2:0]               fine_x
);
    import ppu_pkg::*;

    // shared by PPUSCROLL and PPUADDR
    typedef enum logic {
        FIRST_WRITE  = 1'b0,
        SECOND_WRITE = 1'b1
    } wr_toggle_t;

    wr_toggle_t              toggle;
    logic [`PPU_VADDR_W-1:0] t_addr;
    logic [`PPU_VADDR_W-1:0] v_addr;
    logic [`PPU_VADDR_W-1:0] step;
    logic [`PPU_DATA_W-1:0]  d;

    assign d          = cpu_req.wdata;
    assign step       = vram_inc_32 ? `PPU_VADDR_W'd32 : `PPU_VADDR_W'd1;
    assign video_addr = v_addr;

    // t layout: fine y [14:12], nametable [11:10], coarse y [9:5], coarse x [4:0]
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            toggle <= FIRST_WRITE;
            t_addr <= '0;
            v_addr <= '0;
            fine_x <= '0;
        end else if (cpu_req.en) begin
            case (cpu_req.sel)
                PPUCTRL: begin
                    if (cpu_req.wr) t_addr[11:10] <= d[1:0];
                end
                PPUSTATUS: begin
                    if (!cpu_req.wr) toggle <= FIRST_WRITE;
                end
                PPUSCROLL: begin
                    if (cpu_req.wr && toggle == FIRST_WRITE) begin
                        fine_x      <= d[2:0];
                        t_addr[4:0] <= d[7:3];
                        toggle      <= SECOND_WRITE;
                    end else if (cpu_req.wr) begin
                        t_addr[14:12] <= d[2:0];
                        t_addr[9:5]   <= d[7:3];
                        toggle        <= FIRST_WRITE;
                    end
                end
                PPUADDR: begin
                    if (cpu_req.wr && toggle == FIRST_WRITE) begin
                        // high byte, bit 14 forced low
                        t_addr[14:8] <= {1'b0, d[5:0]};
                        toggle       <= SECOND_WRITE;
                    end else if (cpu_req.wr) begin
                        t_addr[7:0] <= d;
                        v_addr      <= {t_addr[14:8], d};
                        toggle      <= FIRST_WRITE;
                    end
                end
                PPUDATA: begin
                    // wraps naturally at 15 bits
                    v_addr <= v_addr + step;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

// File: ppu_bus/ppu_mem_map.sv
`timescale 1ns/1ps
`include "ppu_params.svh"

module ppu_mem_map (
    input  logic [`PPU_VADDR_W-1:0]  video_addr,
    input  ppu_pkg::cpu_req_t        cpu_req,
    input  ppu_pkg::mirror_t         mirroring,
    output ppu_pkg::chr_port_t       chr,
    input  logic [`PPU_DATA_W-1:0]   chr_rd_data,
    output ppu_pkg::nt_port_t        nt,
    input  logic [`PPU_DATA_W-1:0]   nt_rd_data,
    output ppu_pkg::pal_port_t       pal,
    input  logic [`PPU_DATA_W-1:0]   pal_rd_data,
    output ppu_pkg::vdata_rd_t       vdata_rd
);
    import ppu_pkg::*;

    logic [13:0]             a;
    logic                    data_acc;
    logic                    is_chr;
    logic                    is_nt;
    logic                    is_pal;
    logic                    nt_page;
    logic [`PPU_PAL_AW-1:0]  pal_addr;

    // the ppu bus is only 14 bits wide
    assign a        = video_addr[13:0];
    assign data_acc = cpu_req.en && (cpu_req.sel == PPUDATA);

    assign is_chr = (a < 14'h2000);
    assign is_nt  = !is_chr && (a < 14'h3F00);
    assign is_pal = (a >= 14'h3F00);

    // horizontal: 0x2000/0x2400 share a page, select by bit 11
    assign nt_page = (mirroring == MIRROR_HORZ) ? a[11] : a[10];

    // sprite backdrop entries alias the background ones
    assign pal_addr = (a[1:0] == 2'b00) ? {1'b0, a[3:0]} : a[4:0];

    always_comb begin
        chr.addr  = a[`PPU_CHR_AW-1:0];
        chr.re    = data_acc && !cpu_req.wr && is_chr;
        chr.we    = data_acc && cpu_req.wr && is_chr;
        chr.wdata = cpu_req.wdata;

        nt.addr   = {nt_page, a[9:0]};
        nt.re     = data_acc && !cpu_req.wr && is_nt;
        nt.we     = data_acc && cpu_req.wr && is_nt;
        nt.wdata  = cpu_req.wdata;

        pal.addr  = pal_addr;
        pal.re    = data_acc && !cpu_req.wr && is_pal;
        pal.we    = data_acc && cpu_req.wr && is_pal;
        pal.wdata = cpu_req.wdata;
    end

    // read return, palette flagged so the buffer is skipped
    always_comb begin
        if (is_pal) begin
            vdata_rd.data   = pal_rd_data;
            vdata_rd.bypass = 1'b1;
        end else if (is_nt) begin
            vdata_rd.data   = nt_rd_data;
            vdata_rd.bypass = 1'b0;
        end else begin
            vdata_rd.data   = chr_rd_data;
            vdata_rd.bypass = 1'b0;
        end
    end

endmodule

// File: hw/ppu_reg_top.sv
`timescale 1ns/1ps
`include "ppu_params.svh"

module ppu_reg_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  ppu_pkg::cpu_req_t         cpu_req,
    output logic [`PPU_DATA_W-1:0]    read_data,
    output logic [`PPU_DATA_W-1:0]    ctrl,
    output logic [`PPU_DATA_W-1:0]    mask,
    input  ppu_pkg::status_evt_t      status_evt,
    input  ppu_pkg::mirror_t          mirroring,
    output ppu_pkg::oam_port_t        oam,
    input  logic [`PPU_DATA_W-1:0]    oam_rd_data,
    output ppu_pkg::chr_port_t        chr,
    input  logic [`PPU_DATA_W-1:0]    chr_rd_data,
    output ppu_pkg::nt_port_t         nt,
    input  logic [`PPU_DATA_W-1:0]    nt_rd_data,
    output ppu_pkg::pal_port_t        pal,
    input  logic [`PPU_DATA_W-1:0]    pal_rd_data,
    output logic [`PPU_VADDR_W-1:0]   video_addr,
    output logic [2:0]                fine_x
);
    import ppu_pkg::*;

    logic [`PPU_DATA_W-1:0] status_byte;
    logic                   vram_inc_32;
    vdata_rd_t              vdata_rd;

    ppu_regs u_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .cpu_req     (cpu_req),
        .status_byte (status_byte),
        .vdata_rd    (vdata_rd),
        .oam_rd_data (oam_rd_data),
        .oam         (oam),
        .vram_inc_32 (vram_inc_32),
        .ctrl        (ctrl),
        .mask        (mask),
        .read_data   (read_data)
    );

    ppu_status u_status (
        .clk         (clk),
        .rst_n       (rst_n),
        .cpu_req     (cpu_req),
        .status_evt  (status_evt),
        .status_byte (status_byte)
    );

    loopy_addr u_loopy (
        .clk         (clk),
        .rst_n       (rst_n),
        .cpu_req     (cpu_req),
        .vram_inc_32 (vram_inc_32),
        .video_addr  (video_addr),
        .fine_x      (fine_x)
    );

    ppu_mem_map u_mem_map (
        .video_addr  (video_addr),
        .cpu_req     (cpu_req),
        .mirroring   (mirroring),
        .chr         (chr),
        .chr_rd_data (chr_rd_data),
        .nt          (nt),
        .nt_rd_data  (nt_rd_data),
        .pal         (pal),
        .pal_rd_data (pal_rd_data),
        .vdata_rd    (vdata_rd)
    );

endmodule

// File: tb/ppu_reg_sva.sv
`timescale 1ns/1ps

module ppu_reg_sva (
    input logic                   clk,
    input logic                   rst_n,
    input ppu_pkg::cpu_req_t      cpu_req,
    input ppu_pkg::chr_port_t     chr,
    input ppu_pkg::nt_port_t      nt,
    input ppu_pkg::pal_port_t     pal,
    input ppu_pkg::oam_port_t     oam,
    input logic [7:0]             read_data
);
    import ppu_pkg::*;

    logic any_en;
    logic mem_acc;

    assign any_en  = chr.re || chr.we || nt.re || nt.we || pal.re || pal.we || oam.re || oam.we;
    assign mem_acc = cpu_req.en && (cpu_req.sel == PPUDATA || cpu_req.sel == OAMDATA);

    // one region at a time on the video bus
    a_one_write: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({chr.we, nt.we, pal.we}))
        else $error("more than one memory write enable");

    a_en_needs_acc: assert property (@(posedge clk) disable iff (!rst_n)
        any_en |-> mem_acc)
        else $error("memory enable without a data access");

    // read data only moves after a read
    a_rd_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !(cpu_req.en && !cpu_req.wr) |=> $stable(read_data))
        else $error("read data changed without a read");

endmodule

bind ppu_reg_top ppu_reg_sva i_sva (
    .clk       (clk),
    .rst_n     (rst_n),
    .cpu_req   (cpu_req),
    .chr       (chr),
    .nt        (nt),
    .pal       (pal),
    .oam       (oam),
    .read_data (read_data)
);

// File: tb/ppu_reg_tb.sv
`timescale 1ns/1ps
`include "ppu_params.svh"

module ppu_reg_tb;
    import ppu_pkg::*;

    logic                    clk;
    logic                    rst_n;
    cpu_req_t                cpu_req;
    status_evt_t             status_evt;
    mirror_t                 mirroring;
    logic [`PPU_DATA_W-1:0]  read_data;
    logic [`PPU_DATA_W-1:0]  ctrl;
    logic [`PPU_DATA_W-1:0]  mask;
    logic [`PPU_DATA_W-1:0]  oam_rd_data;
    logic [`PPU_DATA_W-1:0]  chr_rd_data;
    logic [`PPU_DATA_W-1:0]  nt_rd_data;
    logic [`PPU_DATA_W-1:0]  pal_rd_data;
    oam_port_t               oam;
    chr_port_t               chr;
    nt_port_t                nt;
    pal_port_t               pal;
    logic [`PPU_VADDR_W-1:0] video_addr;
    logic [2:0]              fine_x;
    integer                  seed;

    // memories seen by the dut
    logic [7:0] chr_mem [0:8191];
    logic [7:0] nt_mem  [0:2047];
    logic [7:0] pal_mem [0:31];
    logic [7:0] oam_mem [0:255];
    // reference copies
    logic [7:0] ref_chr [0:8191];
    logic [7:0] ref_nt  [0:2047];
    logic [7:0] ref_pal [0:31];
    logic [7:0] ref_oam [0:255];

    // reference register state
    logic [7:0]  r_ctrl, r_mask, r_oam_addr, r_buf, r_rd;
    logic [14:0] r_t, r_v;
    logic [2:0]  r_fx;
    logic        r_toggle, r_ovr, r_zero, r_vbl;
    logic [4:0]  r_last;

    ppu_reg_top i_dut (
        .clk (clk), .rst_n (rst_n), .cpu_req (cpu_req), .read_data (read_data),
        .ctrl (ctrl), .mask (mask), .status_evt (status_evt), .mirroring (mirroring),
        .oam (oam), .oam_rd_data (oam_rd_data), .chr (chr), .chr_rd_data (chr_rd_data),
        .nt (nt), .nt_rd_data (nt_rd_data), .pal (pal), .pal_rd_data (pal_rd_data),
        .video_addr (video_addr), .fine_x (fine_x)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    assign chr_rd_data = chr_mem[chr.addr];
    assign nt_rd_data  = nt_mem[nt.addr];
    assign pal_rd_data = pal_mem[pal.addr];
    assign oam_rd_data = oam_mem[oam.addr];

    always @(posedge clk) begin
        if (chr.we) chr_mem[chr.addr] <= chr.wdata;
        if (nt.we) nt_mem[nt.addr] <= nt.wdata;
        if (pal.we) pal_mem[pal.addr] <= pal.wdata;
        if (oam.we) oam_mem[oam.addr] <= oam.wdata;
    end

    function automatic logic [7:0] fill(input int region, input int addr);
        return 8'(addr ^ (addr >> 8) ^ (region * 8'h5A));
    endfunction

    function automatic logic [7:0] rand8();
        return 8'($random(seed));
    endfunction

    // 0 pattern, 1 nametable, 2 palette
    function automatic int region_of(input logic [13:0] a);
        if (a < 14'h2000) return 0;
        if (a < 14'h3F00) return 1;
        return 2;
    endfunction

    function automatic logic [10:0] nt_index(input logic [13:0] a, input mirror_t m);
        return {(m == MIRROR_HORZ) ? a[11] : a[10], a[9:0]};
    endfunction

    function automatic logic [4:0] pal_index(input logic [13:0] a);
        if (a[4] && a[1:0] == 2'b00) return {1'b0, a[3:0]};
        return a[4:0];
    endfunction

    // expected port structs for the current cycle before the edge
    function automatic chr_port_t exp_chr(input cpu_req_t r);
        chr_port_t p;
        logic acc;
        acc     = r.en && r.sel == PPUDATA && region_of(r_v[13:0]) == 0;
        p.addr  = r_v[12:0];
        p.re    = acc && !r.wr;
        p.we    = acc && r.wr;
        p.wdata = r.wdata;
        return p;
    endfunction

    function automatic nt_port_t exp_nt(input cpu_req_t r, input mirror_t m);
        nt_port_t p;
        logic acc;
        acc     = r.en && r.sel == PPUDATA && region_of(r_v[13:0]) == 1;
        p.addr  = nt_index(r_v[13:0], m);
        p.re    = acc && !r.wr;
        p.we    = acc && r.wr;
        p.wdata = r.wdata;
        return p;
    endfunction

    function automatic pal_port_t exp_pal(input cpu_req_t r);
        pal_port_t p;
        logic acc;
        acc     = r.en && r.sel == PPUDATA && region_of(r_v[13:0]) == 2;
        p.addr  = pal_index(r_v[13:0]);
        p.re    = acc && !r.wr;
        p.we    = acc && r.wr;
        p.wdata = r.wdata;
        return p;
    endfunction

    function automatic oam_port_t exp_oam(input cpu_req_t r);
        oam_port_t p;
        p.addr  = r_oam_addr;
        p.re    = r.en && !r.wr && r.sel == OAMDATA;
        p.we    = r.en && r.wr && r.sel == OAMDATA;
        p.wdata = r.wdata;
        return p;
    endfunction

    // advances the model by one bus cycle
    function automatic void ref_access(input cpu_req_t r, input status_evt_t e,
                                       input mirror_t m);
        logic [13:0] a;
        logic [7:0]  st;
        logic [7:0]  d;
        logic        wr;
        logic        rd;
        a  = r_v[13:0];
        st = {r_vbl, r_zero, r_ovr, r_last};
        d  = r.wdata;
        wr = r.en && r.wr;
        rd = r.en && !r.wr;
        if (e.ovr_set) r_ovr = 1'b1;
        if (e.ovr_clr) r_ovr = 1'b0;
        if (e.zero_set) r_zero = 1'b1;
        if (e.zero_clr) r_zero = 1'b0;
        if (e.vbl_set) r_vbl = 1'b1;
        if (e.vbl_clr || (rd && r.sel == PPUSTATUS)) r_vbl = 1'b0;
        if (wr) r_last = d[4:0];
        if (r.en) begin
            case (r.sel)
                PPUCTRL: if (wr) begin
                    r_ctrl      = d;
                    r_t[11:10]  = d[1:0];
                end
                PPUMASK: if (wr) r_mask = d;
                PPUSTATUS: if (rd) begin
                    r_rd     = st;
                    r_toggle = 1'b0;
                end
                OAMADDR: if (wr) r_oam_addr = d;
                OAMDATA: if (wr) begin
                    ref_oam[r_oam_addr] = d;
                    r_oam_addr          = r_oam_addr + 8'd1;
                end else begin
                    r_rd = ref_oam[r_oam_addr];
                end
                PPUSCROLL: if (wr && !r_toggle) begin
                    r_fx      = d[2:0];
                    r_t[4:0]  = d[7:3];
                    r_toggle  = 1'b1;
                end else if (wr) begin
                    r_t[14:12] = d[2:0];
                    r_t[9:5]   = d[7:3];
                    r_toggle   = 1'b0;
                end
                PPUADDR: if (wr && !r_toggle) begin
                    r_t[14:8] = {1'b0, d[5:0]};
                    r_toggle  = 1'b1;
                end else if (wr) begin
                    r_t[7:0] = d;
                    r_v      = r_t;
                    r_toggle = 1'b0;
                end
                PPUDATA: begin
                    if (region_of(a) == 2) begin
                        if (wr) ref_pal[pal_index(a)] = d;
                        else r_rd = ref_pal[pal_index(a)];
                    end else if (region_of(a) == 1) begin
                        if (wr) ref_nt[nt_index(a, m)] = d;
                        else begin
                            r_rd  = r_buf;
                            r_buf = ref_nt[nt_index(a, m)];
                        end
                    end else begin
                        if (wr) ref_chr[a[12:0]] = d;
                        else begin
                            r_rd  = r_buf;
                            r_buf = ref_chr[a[12:0]];
                        end
                    end
                    r_v = r_v + (r_ctrl[2] ? 15'd32 : 15'd1);
                end
                default: begin
                end
            endcase
        end
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("ERROR t=%0t %s expected %h actual %h", $time, name, exp, act);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (exp !== act) report_mismatch(name, 32'(exp), 32'(act));
    endtask

    task automatic check_vaddr(input logic [14:0] exp, input logic [14:0] act);
        if (exp !== act) report_mismatch("video_addr", 32'(exp), 32'(act));
    endtask

    task automatic check_fine_x(input logic [2:0] exp, input logic [2:0] act);
        if (exp !== act) report_mismatch("fine_x", 32'(exp), 32'(act));
    endtask

    task automatic check_chr(input chr_port_t exp, input chr_port_t act);
        if (exp !== act) report_mismatch("chr", 32'(exp), 32'(act));
    endtask

    task automatic check_nt(input nt_port_t exp, input nt_port_t act);
        if (exp !== act) report_mismatch("nt", 32'(exp), 32'(act));
    endtask

    task automatic check_pal(input pal_port_t exp, input pal_port_t act);
        if (exp !== act) report_mismatch("pal", 32'(exp), 32'(act));
    endtask

    task automatic check_oam(input oam_port_t exp, input oam_port_t act);
        if (exp !== act) report_mismatch("oam", 32'(exp), 32'(act));
    endtask

    // compare on the falling edge once outputs have settled
    always @(negedge clk) begin
        if (rst_n) begin
            check_data("read_data", r_rd, read_data);
            check_data("ctrl", r_ctrl, ctrl);
            check_data("mask", r_mask, mask);
            check_vaddr(r_v, video_addr);
            check_fine_x(r_fx, fine_x);
            check_chr(exp_chr(cpu_req), chr);
            check_nt(exp_nt(cpu_req, mirroring), nt);
            check_pal(exp_pal(cpu_req), pal);
            check_oam(exp_oam(cpu_req), oam);
            ref_access(cpu_req, status_evt, mirroring);
        end
    end

    task automatic bus_cycle(input reg_sel_t s, input logic w, input logic [7:0] d);
        cpu_req_t req;
        req.sel   = s;
        req.en    = 1'b1;
        req.wr    = w;
        req.wdata = d;
        @(posedge clk);
        cpu_req    <= req;
        status_evt <= '0;
    endtask

    task automatic idle_cycle(input status_evt_t e);
        @(posedge clk);
        cpu_req    <= '0;
        status_evt <= e;
    endtask

    task automatic set_vaddr(input logic [14:0] a);
        bus_cycle(PPUADDR, 1'b1, {2'b00, a[13:8]});
        bus_cycle(PPUADDR, 1'b1, a[7:0]);
    endtask

    task automatic data_burst(input logic [14:0] a);
        set_vaddr(a);
        repeat (6) bus_cycle(PPUDATA, 1'b1, rand8());
        set_vaddr(a);
        repeat (7) bus_cycle(PPUDATA, 1'b0, 8'h00);
    endtask

    task automatic events(input logic [5:0] bits);
        idle_cycle(status_evt_t'(bits));
        idle_cycle('0);
        bus_cycle(PPUSTATUS, 1'b0, 8'h00);
    endtask

    initial begin
        int n;
        seed       = 32'h3392_5808;
        rst_n      = 1'b0;
        cpu_req    = '0;
        status_evt = '0;
        mirroring  = MIRROR_HORZ;
        {r_ctrl, r_mask, r_oam_addr, r_buf, r_rd} = '0;
        {r_t, r_v, r_fx, r_toggle, r_ovr, r_zero, r_vbl, r_last} = '0;
        for (n = 0; n < 8192; n++) begin
            chr_mem[n] = fill(0, n);
            ref_chr[n] = fill(0, n);
        end
        for (n = 0; n < 2048; n++) begin
            nt_mem[n] = fill(1, n);
            ref_nt[n] = fill(1, n);
        end
        for (n = 0; n < 256; n++) begin
            oam_mem[n] = fill(3, n);
            ref_oam[n] = fill(3, n);
        end
        for (n = 0; n < 32; n++) begin
            pal_mem[n] = fill(2, n);
            ref_pal[n] = fill(2, n);
        end
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        // plain registers and the last-write bits
        repeat (8) begin
            bus_cycle(PPUCTRL, 1'b1, rand8());
            bus_cycle(PPUSTATUS, 1'b0, 8'h00);
            bus_cycle(PPUMASK, 1'b1, rand8());
            bus_cycle(PPUSTATUS, 1'b0, 8'h00);
            bus_cycle(OAMADDR, 1'b1, rand8());
            bus_cycle(PPUSTATUS, 1'b0, 8'h00);
        end

        // all regions, both step sizes, both mirroring modes
        for (int m = 0; m < 2; m++) begin
            for (int inc = 0; inc < 2; inc++) begin
                idle_cycle('0);
                mirroring <= mirror_t'(m);
                bus_cycle(PPUCTRL, 1'b1, inc[0] ? 8'h04 : 8'h00);
                data_burst(15'h2000 | 15'({rand8(), rand8()} & 16'h0FFF));
                data_burst(15'h3F0C);
                data_burst(15'({rand8(), rand8()} & 16'h1FFF));
            end
        end

        // flags including set and clear together
        events(6'b100000);
        events(6'b001000);
        events(6'b000010);
        events(6'b000011);
        events(6'b011100);
        events(6'b101010);
        idle_cycle(6'b000010);
        bus_cycle(PPUSTATUS, 1'b0, 8'h00);
        bus_cycle(PPUSTATUS, 1'b0, 8'h00);

        // status read drops a half-done address write
        bus_cycle(PPUADDR, 1'b1, 8'h21);
        bus_cycle(PPUSTATUS, 1'b0, 8'h00);
        set_vaddr(15'h2345);

        // scroll
        repeat (3) begin
            bus_cycle(PPUSCROLL, 1'b1, rand8());
            bus_cycle(PPUSCROLL, 1'b1, rand8());
        end

        // shared toggle lets an address write copy the scroll bits into v
        bus_cycle(PPUCTRL, 1'b1, rand8());
        bus_cycle(PPUSCROLL, 1'b1, rand8());
        bus_cycle(PPUADDR, 1'b1, rand8());

        // OAM
        bus_cycle(OAMADDR, 1'b1, 8'hFD);
        repeat (5) bus_cycle(OAMDATA, 1'b1, rand8());
        for (int i = 0; i < 5; i++) begin
            bus_cycle(OAMADDR, 1'b1, 8'(8'hFD + i));
            bus_cycle(OAMDATA, 1'b0, 8'h00);
        end

        repeat (3) idle_cycle('0);
        @(posedge clk);
        $display("Everything OK");
        $finish;
    end

    initial begin
        int cycles;
        for (cycles = 0; cycles < 20000; cycles++) @(posedge clk);
        $display("timeout, the run did not finish in time");
        $display("Something failed");
        $fatal(1);
    end

endmodule

// File: ppu_reg_top.f
+incdir+common
common/ppu_pkg.sv
hw/ppu_regs.sv
hw/ppu_status.sv
vram_addr/loopy_addr.sv
ppu_bus/ppu_mem_map.sv
hw/ppu_reg_top.sv
tb/ppu_reg_sva.sv
tb/ppu_reg_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module ppu_reg_tb -f ppu_reg_top.f

status=0
out=$(./obj_dir/Vppu_reg_tb 2>&1) || status=$?
echo "$out"

if echo "$out" | grep -q "Everything OK"; then
    exit 0
fi
echo "simulation failed, status $status"
exit 1
